//--- all.f
src/mcPkg.sv
src/mcCsrBus.sv
src/mcSequencer.sv
src/mcDatapath.sv
src/mcTop.sv
verification/mcTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module mcTb -f all.f -o mcSim > sim.log 2>&1 \
   && ./obj_dir/mcSim >> sim.log 2>&1 \
   || echo "build or simulation exited with an error" >> sim.log
cat sim.log
if grep -q "test failed" sim.log || ! grep -q "test passed" sim.log
then
   exit 1
fi
exit 0

//--- src/mcCsrBus.sv
// AXI4-Lite slave holding the mode bits, maintenance instruction and step counter
module mcCsrBus import mcPkg::*;
(
   input  logic               clk,
   input  logic               arstN,
   input  mcAxiReqS           axiReq,
   output mcAxiRspS           axiRsp,
   input  logic               execEn,
   input  logic [pcWidth-1:0] pc,
   input  logic [7:0]         acc,
   input  logic [7:0]         brg,
   input  mcFlagsS            flags,
   output mcSeqCtlS           seqCtl
);

   mcBusStateE              state;
   mcModeS                  modeReg;
   mcMicroS                 instReg;
   logic [stepWidth-1:0]    stepCnt;
   logic                    wrAccept;
   logic                    rdAccept;
   logic                    wrMapped;
   logic                    rdMapped;
   logic                    wrCtrl;
   logic                    wrAddr;
   logic                    wrInst;
   logic                    wrStep;
   logic [axiDataWidth-1:0] rdMux;
   logic [axiDataWidth-1:0] rdData;
   logic [1:0]              bResp;
   logic [1:0]              rResp;

   ////////////////////////////////////////
   // Handshake and decode
   ////////////////////////////////////////

   // Address and data taken together, writes win over reads
   assign wrAccept = (state == busIdle) && axiReq.awvalid && axiReq.wvalid;
   assign rdAccept = (state == busIdle) && !wrAccept && axiReq.arvalid;

   // Status is read only
   assign wrMapped = axiReq.awaddr inside {csrCtrl, csrAddr, csrInst, csrStep};

   assign wrCtrl = wrAccept && (axiReq.awaddr == csrCtrl);
   assign wrAddr = wrAccept && (axiReq.awaddr == csrAddr);
   assign wrInst = wrAccept && (axiReq.awaddr == csrInst);
   assign wrStep = wrAccept && (axiReq.awaddr == csrStep);

   // Read mux
   always_comb
   begin
      rdMux    = '0;
      rdMapped = 1'b1;
      case (axiReq.araddr)
         csrCtrl:   rdMux = {29'b0, modeReg};
         csrAddr:   rdMux = {22'b0, pc};
         csrInst:   rdMux = {16'b0, instReg};
         // Busy flag on top of the remaining count
         csrStep:   rdMux = {stepCnt != '0, stepCnt};
         csrStatus: rdMux = {4'b0, pc, flags.zero, flags.carry, brg, acc};
         default:   rdMapped = 1'b0;
      endcase
   end

   ////////////////////////////////////////
   // Transaction FSM
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
         state <= busIdle;
      else
      begin
         case (state)
            busIdle:
            begin
               if (wrAccept)
                  state <= busWrResp;
               else if (rdAccept)
                  state <= busRdResp;
            end
            busWrResp:
               if (axiReq.bready)
                  state <= busIdle;
            busRdResp:
               if (axiReq.rready)
                  state <= busIdle;
            default:
               state <= busIdle;
         endcase
      end
   end

   // Response payload, captured at the handshake
   always_ff @(posedge clk)
   begin
      if (wrAccept)
         bResp <= wrMapped ? respOkay : respSlvErr;
      if (rdAccept)
      begin
         rdData <= rdMux;
         rResp  <= rdMapped ? respOkay : respSlvErr;
      end
   end

   ////////////////////////////////////////
   // CSR registers
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         modeReg <= '0;
         instReg <= '0;
         stepCnt <= '0;
      end
      else
      begin
         if (wrCtrl)
            modeReg <= mcModeS'(axiReq.wdata[2:0]);
         if (wrInst)
            instReg <= mcMicroS'(axiReq.wdata[15:0]);
         // New count restarts the run, otherwise count down per instruction
         if (wrStep)
            stepCnt <= axiReq.wdata[stepWidth-1:0];
         else if (execEn && (stepCnt != '0))
            stepCnt <= stepCnt - 1'b1;
      end
   end

   // Response channels
   assign axiRsp.awready = wrAccept;
   assign axiRsp.wready  = wrAccept;
   assign axiRsp.bvalid  = (state == busWrResp);
   assign axiRsp.bresp   = bResp;
   assign axiRsp.arready = rdAccept;
   assign axiRsp.rvalid  = (state == busRdResp);
   assign axiRsp.rdata   = rdData;
   assign axiRsp.rresp   = rResp;

   // Sequencer control, loads act on the handshake edge
   assign seqCtl.mode     = modeReg;
   assign seqCtl.pcLoad   = wrAddr && modeReg.cramOut;
   assign seqCtl.pcData   = axiReq.wdata[pcWidth-1:0];
   assign seqCtl.instLoad = wrInst;
   assign seqCtl.instData = mcMicroS'(axiReq.wdata[15:0]);
   assign seqCtl.cramWr   = wrCtrl && axiReq.wdata[3];
   assign seqCtl.run      = (stepCnt != '0);

endmodule

//--- src/mcDatapath.sv
// Byte datapath with accumulator, ALU, flags and branch register
module mcDatapath import mcPkg::*;
(
   input  logic       clk,
   input  logic       arstN,
   input  logic       init,
   input  mcMicroS    micro,
   input  logic       execEn,
   output logic [7:0] acc,
   output logic [7:0] brg,
   output mcFlagsS    flags
);

   logic [8:0] sum;
   logic [7:0] result;
   logic       writesAcc;

   ////////////////////////////////////////
   // ALU
   ////////////////////////////////////////

   // Ninth bit is the carry out
   assign sum = {1'b0, acc} + {1'b0, micro.imm};

   always_comb
   begin
      case (micro.op)
         opLdi:   result = micro.imm;
         opAdd:   result = sum[7:0];
         opAnd:   result = acc & micro.imm;
         opXor:   result = acc ^ micro.imm;
         default: result = acc;
      endcase
   end

   // Same set of ops also sets zero
   assign writesAcc = micro.op inside {opLdi, opAdd, opAnd, opXor};

   ////////////////////////////////////////
   // Registers
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         acc   <= '0;
         brg   <= '0;
         flags <= '0;
      end
      else if (init)
      begin
         acc   <= '0;
         brg   <= '0;
         flags <= '0;
      end
      else if (execEn)
      begin
         if (writesAcc)
         begin
            acc        <= result;
            flags.zero <= (result == 8'h00);
         end
         // Carry only from add
         if (micro.op == opAdd)
            flags.carry <= sum[8];
         if (micro.op == opMovBrg)
            brg <= acc;
         // Jumps and nop leave the datapath alone
      end
   end

endmodule

//--- src/mcPkg.sv
// Shared types, microword layout and CSR map of the microcoded byte engine
package mcPkg;

   ////////////////////////////////////////
   // Sizes
   ////////////////////////////////////////

   localparam int cramDepth    = 1024;
   localparam int pcWidth      = 10;
   // Remaining-step counter, bit 31 of csrStep is busy
   localparam int stepWidth    = 31;
   localparam int axiAddrWidth = 5;
   localparam int axiDataWidth = 32;

   // CSR offsets
   localparam logic [axiAddrWidth-1:0] csrCtrl   = 5'h00;
   localparam logic [axiAddrWidth-1:0] csrAddr   = 5'h04;
   localparam logic [axiAddrWidth-1:0] csrInst   = 5'h08;
   localparam logic [axiAddrWidth-1:0] csrStep   = 5'h0C;
   localparam logic [axiAddrWidth-1:0] csrStatus = 5'h10;

   // AXI response codes
   localparam logic [1:0] respOkay   = 2'b00;
   localparam logic [1:0] respSlvErr = 2'b10;

   ////////////////////////////////////////
   // Microword
   ////////////////////////////////////////

   typedef enum logic [2:0] {
      opNop, opLdi, opAdd, opAnd, opXor, opMovBrg, opJmpImm, opJmpAcc
   } mcOpE;

   // Branch conditions, only looked at by jumps
   typedef enum logic [2:0] {
      condAlways, condNever, condCarry, condZero, condBrg0, condBrg1, condBrg4, condBrg7
   } mcCondE;

   // Page gives the two high bits of a jump target
   typedef struct packed {
      mcOpE       op;
      mcCondE     cond;
      logic [1:0] page;
      logic [7:0] imm;
   } mcMicroS;

   typedef enum logic {phFetch, phExec} mcPhaseE;

   typedef enum logic [1:0] {busIdle, busWrResp, busRdResp} mcBusStateE;

   ////////////////////////////////////////
   // Inter-block bundles
   ////////////////////////////////////////

   // Laid out so that cramIn lands on bit 0 of csrCtrl
   typedef struct packed {
      logic init;
      logic cramOut;
      logic cramIn;
   } mcModeS;

   typedef struct packed {
      mcModeS             mode;
      logic               pcLoad;
      logic [pcWidth-1:0] pcData;
      logic               instLoad;
      mcMicroS            instData;
      logic               cramWr;
      logic               run;
   } mcSeqCtlS;

   typedef struct packed {
      logic carry;
      logic zero;
   } mcFlagsS;

   // AXI4-Lite master to slave
   typedef struct packed {
      logic                    awvalid;
      logic [axiAddrWidth-1:0] awaddr;
      logic                    wvalid;
      logic [axiDataWidth-1:0] wdata;
      logic                    bready;
      logic                    arvalid;
      logic [axiAddrWidth-1:0] araddr;
      logic                    rready;
   } mcAxiReqS;

   // AXI4-Lite slave to master
   typedef struct packed {
      logic                    awready;
      logic                    wready;
      logic                    bvalid;
      logic [1:0]              bresp;
      logic                    arready;
      logic                    rvalid;
      logic [axiDataWidth-1:0] rdata;
      logic [1:0]              rresp;
   } mcAxiRspS;

endpackage

//--- src/mcSequencer.sv
// Microsequencer with PC, branch decoder, control RAM and maintenance instruction path
module mcSequencer import mcPkg::*;
(
   input  logic               clk,
   input  logic               arstN,
   input  mcSeqCtlS           seqCtl,
   input  mcFlagsS            flags,
   input  logic [7:0]         acc,
   input  logic [7:0]         brg,
   output mcMicroS            micro,
   output logic               execEn,
   output logic [pcWidth-1:0] pc
);

   mcMicroS cram [cramDepth];
   mcMicroS fetchReg;
   mcMicroS mntInst;
   mcPhaseE phase;
   logic    active;
   logic    isJump;
   logic    taken;

   // Stepping is blocked while the control RAM is open to the host
   assign active = seqCtl.run && !seqCtl.mode.cramOut;
   assign execEn = active && (phase == phExec);

   ////////////////////////////////////////
   // Branch decoder
   ////////////////////////////////////////

   assign isJump = (micro.op == opJmpImm) || (micro.op == opJmpAcc);

   always_comb
   begin
      case (micro.cond)
         condAlways: taken = 1'b1;
         condNever:  taken = 1'b0;
         condCarry:  taken = flags.carry;
         condZero:   taken = flags.zero;
         condBrg0:   taken = brg[0];
         condBrg1:   taken = brg[1];
         condBrg4:   taken = brg[4];
         condBrg7:   taken = brg[7];
         default:    taken = 1'b0;
      endcase
   end

   ////////////////////////////////////////
   // Phase and program counter
   ////////////////////////////////////////

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         phase <= phFetch;
         pc    <= '0;
      end
      else if (seqCtl.mode.init)
      begin
         phase <= phFetch;
         pc    <= '0;
      end
      else
      begin
         // Fetch and execute alternate, two cycles per instruction
         if (!active)
            phase <= phFetch;
         else
            phase <= (phase == phFetch) ? phExec : phFetch;

         if (seqCtl.mode.cramOut)
         begin
            if (seqCtl.pcLoad)
               pc <= seqCtl.pcData;
         end
         // Maintenance execution leaves the PC alone
         else if (execEn && !seqCtl.mode.cramIn)
         begin
            if (isJump && taken)
               pc <= {micro.page, (micro.op == opJmpAcc) ? acc : micro.imm};
            else
               pc <= pc + 1'b1;
         end
      end
   end

   // Maintenance instruction register
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
         mntInst <= '0;
      else if (seqCtl.instLoad)
         mntInst <= seqCtl.instData;
   end

   ////////////////////////////////////////
   // Control RAM
   ////////////////////////////////////////

   // Host writes at the PC, engine fetches at the PC
   always_ff @(posedge clk)
   begin
      if (seqCtl.mode.cramOut && seqCtl.cramWr)
         cram[pc] <= mntInst;
      else if (active && (phase == phFetch))
         fetchReg <= cram[pc];
   end

   // Maintenance mux
   assign micro = seqCtl.mode.cramIn ? mntInst : fetchReg;

endmodule

//--- src/mcTop.sv
// Top level of the microcoded byte engine with its AXI4-Lite CSR port
module mcTop import mcPkg::*;
(
   input  logic     clk,
   input  logic     arstN,
   input  mcAxiReqS axiReq,
   output mcAxiRspS axiRsp
);

   mcSeqCtlS           seqCtl;
   mcMicroS            micro;
   mcFlagsS            flags;
   logic               execEn;
   logic [pcWidth-1:0] pc;
   logic [7:0]         acc;
   logic [7:0]         brg;

   // Host side
   mcCsrBus i_csrBus (
      .clk    (clk),
      .arstN  (arstN),
      .axiReq (axiReq),
      .axiRsp (axiRsp),
      .execEn (execEn),
      .pc     (pc),
      .acc    (acc),
      .brg    (brg),
      .flags  (flags),
      .seqCtl (seqCtl)
   );

   // Fetch, branch and maintenance path
   mcSequencer i_sequencer (
      .clk    (clk),
      .arstN  (arstN),
      .seqCtl (seqCtl),
      .flags  (flags),
      .acc    (acc),
      .brg    (brg),
      .micro  (micro),
      .execEn (execEn),
      .pc     (pc)
   );

   // Init bit clears the datapath too
   mcDatapath i_datapath (
      .clk    (clk),
      .arstN  (arstN),
      .init   (seqCtl.mode.init),
      .micro  (micro),
      .execEn (execEn),
      .acc    (acc),
      .brg    (brg),
      .flags  (flags)
   );

endmodule

//--- verification/mcTb.sv
// Testbench for the microcoded byte engine with AXI4-Lite bus tasks and a reference model
module mcTb import mcPkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   // Architectural state as seen through csrStatus
   typedef struct packed {
      logic [pcWidth-1:0] pc;
      logic [7:0]         acc;
      logic [7:0]         brg;
      mcFlagsS            flags;
   } engStateS;

   ////////////////////////////////////////
   // Run length bound
   ////////////////////////////////////////

   // Upper bound of cycles per bus transaction
   localparam int busCycles = 4;
   // Transactions over all tests including polls
   localparam int txTotal   = 2 + (27 + 8 * 4) + (51 + 18) + 16 * (18 + 6) + 16 + 4;
   localparam int stepTotal = 8 + 16 + 16 * 5 + 2;
   localparam int cycleLimit = 2 * (txTotal * busCycles + 2 * stepTotal);

   logic        clk;
   logic        arstN;
   mcAxiReqS    axiReq;
   mcAxiRspS    axiRsp;
   mcMicroS     cramCopy [cramDepth];
   logic [15:0] lfsrState;
   engStateS    model;
   engStateS    dutState;
   engStateS    expState;
   int          cycleCount = 0;
   event        compareEv;

   mcTop i_dut (
      .clk    (clk),
      .arstN  (arstN),
      .axiReq (axiReq),
      .axiRsp (axiRsp)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   ////////////////////////////////////////
   // Error handling and compares
   ////////////////////////////////////////

   task automatic stopOnError(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic checkPc(input string name, input logic [pcWidth-1:0] got,
                          input logic [pcWidth-1:0] exp);
      if (got !== exp)
         stopOnError($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp)
         stopOnError($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   task automatic checkFlags(input string name, input mcFlagsS got, input mcFlagsS exp);
      if (got !== exp)
         stopOnError($sformatf("Fail %s got 0x%h expected 0x%h", name, got, exp));
   endtask

   // Compare process woken by the test sequence
   always @(compareEv)
   begin
      checkPc("pc", dutState.pc, expState.pc);
      checkByte("acc", dutState.acc, expState.acc);
      checkByte("brg", dutState.brg, expState.brg);
      checkFlags("flags", dutState.flags, expState.flags);
   end

   // Timeout
   always @(posedge clk)
   begin
      cycleCount = cycleCount + 1;
      if (cycleCount > cycleLimit)
         stopOnError($sformatf("timeout, run not finished within %0d cycles", cycleLimit));
   end

   ////////////////////////////////////////
   // Random source
   ////////////////////////////////////////

   // Taps 16 14 13 11
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   // One LFSR step per bit
   function automatic logic [15:0] takeBits(input int n);
      logic [15:0] r;
      r = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsrState = lfsrNext(lfsrState);
         r = {r[14:0], lfsrState[0]};
      end
      return r;
   endfunction

   function automatic mcMicroS randomWord(input mcOpE op);
      mcMicroS m;
      m = mcMicroS'(takeBits(16));
      m.op = op;
      return m;
   endfunction

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   // Runs n instructions from the RAM copy or the given maintenance word
   function automatic engStateS refRun(input engStateS s, input int steps,
                                       input logic maint, input mcMicroS mntWord);
      engStateS   r;
      mcMicroS    m;
      logic [8:0] sum;
      logic       taken;
      r = s;
      for (int i = 0; i < steps; i++)
      begin
         m = maint ? mntWord : cramCopy[r.pc];
         sum = {1'b0, r.acc} + {1'b0, m.imm};
         case (m.cond)
            condAlways: taken = 1'b1;
            condNever:  taken = 1'b0;
            condCarry:  taken = r.flags.carry;
            condZero:   taken = r.flags.zero;
            condBrg0:   taken = r.brg[0];
            condBrg1:   taken = r.brg[1];
            condBrg4:   taken = r.brg[4];
            condBrg7:   taken = r.brg[7];
            default:    taken = 1'b0;
         endcase
         case (m.op)
            opLdi:    r.acc = m.imm;
            opAdd:
            begin
               r.acc = sum[7:0];
               r.flags.carry = sum[8];
            end
            opAnd:    r.acc = r.acc & m.imm;
            opXor:    r.acc = r.acc ^ m.imm;
            opMovBrg: r.brg = r.acc;
            default:  ;
         endcase
         if (m.op inside {opLdi, opAdd, opAnd, opXor})
            r.flags.zero = (r.acc == 8'h00);
         // PC frozen in maintenance mode
         if (!maint)
         begin
            if ((m.op inside {opJmpImm, opJmpAcc}) && taken)
               r.pc = {m.page, (m.op == opJmpAcc) ? r.acc : m.imm};
            else
               r.pc = r.pc + 10'd1;
         end
      end
      return r;
   endfunction

   ////////////////////////////////////////
   // Bus tasks
   ////////////////////////////////////////

   task automatic nextDrive();
      @(posedge clk);
      #10;
   endtask

   task automatic axiWrite(input logic [axiAddrWidth-1:0] addr, input logic [31:0] data);
      nextDrive();
      axiReq.awvalid = 1'b1;
      axiReq.awaddr  = addr;
      axiReq.wvalid  = 1'b1;
      axiReq.wdata   = data;
      // Sampled mid cycle away from the edge
      @(negedge clk);
      while (!(axiRsp.awready && axiRsp.wready))
         @(negedge clk);
      nextDrive();
      axiReq.awvalid = 1'b0;
      axiReq.wvalid  = 1'b0;
      axiReq.bready  = 1'b1;
      @(negedge clk);
      while (!axiRsp.bvalid)
         @(negedge clk);
      if (axiRsp.bresp != respOkay)
         stopOnError($sformatf("write to offset 0x%h was not answered with OKAY", addr));
      nextDrive();
      axiReq.bready = 1'b0;
   endtask

   task automatic axiRead(input logic [axiAddrWidth-1:0] addr, output logic [31:0] data,
                          input logic expectErr);
      nextDrive();
      axiReq.arvalid = 1'b1;
      axiReq.araddr  = addr;
      @(negedge clk);
      while (!axiRsp.arready)
         @(negedge clk);
      nextDrive();
      axiReq.arvalid = 1'b0;
      axiReq.rready  = 1'b1;
      @(negedge clk);
      while (!axiRsp.rvalid)
         @(negedge clk);
      data = axiRsp.rdata;
      if (axiRsp.rresp != (expectErr ? respSlvErr : respOkay))
         stopOnError($sformatf("read of offset 0x%h gave an unexpected response", addr));
      nextDrive();
      axiReq.rready = 1'b0;
   endtask

   // Copies the RAM image in maintenance mode and leaves the PC at start
   task automatic loadProgram(input logic [pcWidth-1:0] start, input int count);
      logic [pcWidth-1:0] a;
      axiWrite(csrCtrl, 32'h2);
      for (int i = 0; i < count; i++)
      begin
         a = start + pcWidth'(i);
         axiWrite(csrAddr, 32'(a));
         axiWrite(csrInst, 32'(cramCopy[a]));
         // Keep cramOut and pulse the RAM write
         axiWrite(csrCtrl, 32'hA);
      end
      axiWrite(csrAddr, 32'(start));
      axiWrite(csrCtrl, 32'h0);
      model.pc = start;
   endtask

   // Start a run and poll until busy drops
   task automatic runSteps(input int n);
      logic [31:0] d;
      axiWrite(csrStep, 32'(n));
      d = 32'h8000_0000;
      while (d[31])
         axiRead(csrStep, d, 1'b0);
   endtask

   task automatic checkState(input engStateS exp);
      logic [31:0] d;
      axiRead(csrStatus, d, 1'b0);
      dutState.acc         = d[7:0];
      dutState.brg         = d[15:8];
      dutState.flags.carry = d[16];
      dutState.flags.zero  = d[17];
      dutState.pc          = d[27:18];
      expState = exp;
      -> compareEv;
      @(posedge clk);
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial
   begin
      logic [31:0]        d;
      mcMicroS            m;
      mcMicroS            addWord;
      mcOpE               op;
      logic [pcWidth-1:0] base;
      axiReq    = '0;
      arstN     = 1'b0;
      lfsrState = 16'd46773;
      model     = '0;
      repeat (3) @(posedge clk);
      #10;
      arstN = 1'b1;

      // Everything zero and idle after reset
      checkState(model);
      axiRead(csrStep, d, 1'b0);
      if (d[31])
         stopOnError("engine reports busy right after reset");

      // Random loads one step at a time
      for (int i = 0; i < 8; i++)
         cramCopy[i] = randomWord(opLdi);
      loadProgram(10'h000, 8);
      for (int i = 0; i < 8; i++)
      begin
         runSteps(1);
         model = refRun(model, 1, 1'b0, '0);
         checkState(model);
      end

      // Random ALU mix in a single run
      base = 10'h040;
      for (int i = 0; i < 16; i++)
      begin
         op = mcOpE'(3'd1 + 3'(takeBits(3) % 16'd5));
         cramCopy[base + 10'(i)] = randomWord(op);
      end
      loadProgram(base, 16);
      runSteps(16);
      model = refRun(model, 16, 1'b0, '0);
      checkState(model);

      // Each condition for both jump kinds with brg and flags preset first
      for (int k = 0; k < 16; k++)
      begin
         base = 10'h300 + 10'(k * 8);
         cramCopy[base] = randomWord(opLdi);
         cramCopy[base + 10'd1] = randomWord(opMovBrg);
         m = randomWord(opLdi);
         cramCopy[base + 10'd2] = m;
         // Second half of the programs add up to zero with a carry
         addWord = randomWord(opAdd);
         if (k[3])
            addWord.imm = 8'h00 - m.imm;
         cramCopy[base + 10'd3] = addWord;
         if (k < 8)
            op = opJmpImm;
         else
            op = opJmpAcc;
         m = randomWord(op);
         m.cond = mcCondE'(3'(k));
         m.page = 2'(k);
         cramCopy[base + 10'd4] = m;
         loadProgram(base, 5);
         runSteps(5);
         model = refRun(model, 5, 1'b0, '0);
         checkState(model);
      end

      // Maintenance execution from csrInst
      axiWrite(csrCtrl, 32'h1);
      m = randomWord(opLdi);
      axiWrite(csrInst, 32'(m));
      runSteps(1);
      model = refRun(model, 1, 1'b1, m);
      checkState(model);
      m = randomWord(opMovBrg);
      axiWrite(csrInst, 32'(m));
      runSteps(1);
      model = refRun(model, 1, 1'b1, m);
      checkState(model);
      axiWrite(csrCtrl, 32'h0);

      // Init clears engine state
      axiWrite(csrCtrl, 32'h4);
      axiWrite(csrCtrl, 32'h0);
      model = '0;
      checkState(model);

      // Unmapped offset
      axiRead(5'h14, d, 1'b1);

      $display("test passed");
      $finish;
   end

endmodule
